/* ooo_core.f */
rtl/ooo_pkg.sv
rtl/instruction_queue.sv
rtl/dispatch.sv
rtl/register_file.sv
rtl/reorder_buffer.sv
rtl/reservation_station.sv
rtl/alu.sv
rtl/multiplier.sv
rtl/cdb_arbiter.sv
rtl/ooo_core.sv
testbench/ooo_core_props.sv
testbench/tb_ooo_core.sv

/* testbench/tb_ooo_core.sv */
`timescale 1ns/10ps

module tb_ooo_core
  import ooo_pkg::*;
();
  localparam int WAIT_LIMIT = 2000; // cycles before a wait gives up

  logic        clk_100mhz;
  logic        sys_rst;
  logic        i_inst_valid;
  logic [31:0] i_inst;
  logic        o_inst_ready;
  logic        o_commit_valid;
  reg_addr_t   o_commit_rd;
  data_t       o_commit_value;

  logic [31:0] rng_state;
  logic [31:0] model_regs [32];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];
  logic [4:0]  last_rd;
  logic        ready_dropped;
  logic [4:0]  want_rd;
  logic [31:0] want_val;
  int          errors;
  int          commits;
  int          tests;

  ooo_core i_ooo_core (
    .clk_100mhz, .sys_rst, .i_inst_valid, .i_inst, .o_inst_ready,
    .o_commit_valid, .o_commit_rd, .o_commit_value
  );

  always #5 clk_100mhz = ~clk_100mhz;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int pick(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n; // upper lcg bits are the random ones
  endfunction

  // rv32i integer result for funct3 with alt selecting sub and sra
  function automatic logic [31:0] int_op(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] s;
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) s = $signed(a) >>> b[4:0];
        else s = a >> b[4:0];
        return s;
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // in-order reference that queues the commit of each supported word
  function automatic void model_step(input logic [31:0] w);
    logic [6:0]         opc;
    logic [6:0]         f7;
    logic [2:0]         f3;
    logic [4:0]         rd;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        imm;
    logic [31:0]        v;
    logic signed [63:0] ps;
    logic [63:0]        pu;
    logic               keep;
    opc  = w[6:0];
    f7   = w[31:25];
    f3   = w[14:12];
    rd   = w[11:7];
    a    = model_regs[w[19:15]];
    b    = model_regs[w[24:20]];
    imm  = {{20{w[31]}}, w[31:20]};
    keep = 1'b1;
    v    = '0;
    if (opc == OPC_OP && f7 == 7'b0000001) begin
      ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
      pu = {32'b0, a} * {32'b0, b};
      case (f3)
        3'd0: v = ps[31:0];
        3'd1: v = ps[63:32];
        3'd3: v = pu[63:32];
        default: keep = 1'b0; // mulhsu and divides
      endcase
    end else if (opc == OPC_OP) begin
      if (f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5)))
        v = int_op(f3, f7[5], a, b);
      else
        keep = 1'b0;
    end else if (opc == OPC_OPIMM) begin
      if (f3 == 3'd1 && f7 != 7'b0) keep = 1'b0;
      else if (f3 == 3'd5 && f7 != 7'b0 && f7 != 7'b0100000) keep = 1'b0;
      else v = int_op(f3, f3 == 3'd5 && f7[5], a, imm); // addi never subtracts
    end else if (opc == OPC_LUI) begin
      v = {w[31:12], 12'b0};
    end else begin
      keep = 1'b0;
    end
    if (keep) begin
      if (rd != 5'd0) model_regs[rd] = v; // x0 stays zero
      exp_rd.push_back(rd);
      exp_val.push_back(v);
    end
  endfunction

  // kind 0 is reg-reg, 1 immediate, 2 lui, 3 multiply and 4 unsupported
  function automatic logic [31:0] gen_word(input int mode);
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic [31:0] r;
    logic [31:0] w;
    rd  = 5'(pick(8));
    rs1 = 5'(pick(8));
    rs2 = 5'(pick(8));
    r   = next_rand();
    case (mode)
      0: kind = pick(3);
      1: kind = (pick(10) < 3) ? 3 : pick(2);
      2: kind = (pick(2) == 0) ? 3 : pick(3);
      3: kind = 3;
      default: kind = (pick(4) == 0) ? 4 : pick(4);
    endcase
    if (mode == 1 && pick(4) != 0) rs1 = last_rd; // chain on previous result
    if (mode == 1 && pick(2) != 0) rs2 = last_rd;
    f3 = 3'(pick(8));
    case (kind)
      0: begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && pick(2) != 0) ? 7'b0100000 : 7'b0;
        w  = {f7, rs2, rs1, f3, rd, OPC_OP};
      end
      1: begin
        imm12 = r[11:0];
        if (f3 == 3'd1) imm12[11:5] = 7'b0;
        if (f3 == 3'd5) imm12[11:5] = (pick(2) != 0) ? 7'b0100000 : 7'b0;
        w = {imm12, rs1, f3, rd, OPC_OPIMM};
      end
      2: w = {r[31:12], rd, OPC_LUI};
      3: begin
        f3 = (pick(3) == 2) ? 3'd3 : 3'(pick(2));
        w  = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
      end
      default: begin
        case (pick(3))
          0: w = {r[31:7], 7'b0000011}; // load
          1: w = {r[31:7], 7'b1100011}; // branch
          default: w = {7'b0000001, rs2, rs1, 3'b100, rd, OPC_OP}; // div
        endcase
      end
    endcase
    last_rd = rd;
    return w;
  endfunction

  task automatic abort_run(input string why);
    $display("timeout: %s at %0t", why, $time);
    $display("Regression failed");
    $finish;
  endtask

  // one word per two cycles so ready cannot fall under an offered word
  task automatic send_word(input logic [31:0] w);
    int t;
    t = 0;
    @(negedge clk_100mhz);
    while (!o_inst_ready && t < WAIT_LIMIT) begin
      @(negedge clk_100mhz);
      t++;
    end
    if (!o_inst_ready) begin
      abort_run("o_inst_ready stayed low");
    end else begin
      @(posedge clk_100mhz);
      i_inst_valid <= 1'b1;
      i_inst       <= w;
      @(posedge clk_100mhz);
      i_inst_valid <= 1'b0; // taken on this edge
      model_step(w);
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_rd.size() != 0 && t < WAIT_LIMIT) begin
      @(negedge clk_100mhz);
      t++;
    end
    if (exp_rd.size() != 0) abort_run("commits stopped with instructions outstanding");
  endtask

  task automatic run_test(input string name, input int mode, input int n);
    int mark;
    mark          = errors;
    ready_dropped = 1'b0;
    for (int k = 0; k < n; k++) send_word(gen_word(mode));
    wait_drain();
    if (mode == 3 && !ready_dropped) begin
      $display("%s: o_inst_ready never dropped, queue did not fill", name);
      errors++;
    end
    tests++;
    $display("%-10s %0d words, %0d errors", name, n, errors - mark);
  endtask

  always @(posedge clk_100mhz) begin
    if (!sys_rst) begin
      if (!o_inst_ready) ready_dropped = 1'b1;
      if (i_ooo_core.u_cdb.o_alu_read && i_ooo_core.u_cdb.o_mul_read) begin
        $display("cdb arbiter acknowledged both units at %0t", $time);
        errors++;
      end
      if (i_ooo_core.u_cdb.o_cdb_valid &&
          i_ooo_core.u_cdb.o_alu_read == i_ooo_core.u_cdb.o_mul_read) begin
        $display("cdb broadcast without a single unit acknowledged at %0t", $time);
        errors++;
      end
      if (o_commit_valid) begin
        if (exp_rd.size() == 0) begin
          $display("unexpected commit of x%0d at %0t with nothing outstanding",
                   o_commit_rd, $time);
          errors++;
        end else begin
          want_rd  = exp_rd.pop_front();
          want_val = exp_val.pop_front();
          if (o_commit_rd !== want_rd || o_commit_value !== want_val) begin
            $display("[ERROR] %0t commit x%0d = %h, expected x%0d = %h", $time,
                     o_commit_rd, o_commit_value, want_rd, want_val);
            errors++;
          end
          commits++;
        end
      end
    end
  end

  initial begin
    int mark;
    clk_100mhz    = 1'b0;
    sys_rst       = 1'b1;
    i_inst_valid  = 1'b0;
    i_inst        = '0;
    rng_state     = 32'h8490_a46c;
    last_rd       = '0;
    ready_dropped = 1'b0;
    errors        = 0;
    commits       = 0;
    tests         = 0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    repeat (2) @(posedge clk_100mhz);
    sys_rst <= 1'b0;

    mark = errors; // idle core before any word
    for (int c = 0; c < 10; c++) begin
      @(negedge clk_100mhz);
      if (o_commit_valid || !o_inst_ready || i_ooo_core.u_cdb.o_cdb_valid) begin
        $display("[ERROR] %0t core not idle after reset", $time);
        errors++;
      end
    end
    tests++;
    $display("%-10s %0d errors", "reset", errors - mark);

    run_test("alu_imm", 0, 32);
    run_test("dep_chain", 1, 40);
    run_test("mul_mix", 2, 40);
    run_test("mul_burst", 3, 24);
    run_test("bad_ops", 4, 48);

    $display("tests=%0d commits=%0d errors=%0d", tests, commits, errors);
    if (errors == 0) $display("Regression passed");
    else $display("Regression failed");
    $finish;
  end

endmodule

/* testbench/ooo_core_props.sv */
`timescale 1ns/10ps

module ooo_core_props (
  input logic clk_100mhz,
  input logic sys_rst,
  input logic i_alu_read,
  input logic i_mul_read,
  input logic i_cdb_valid
);

  a_single_read: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst)
    !(i_alu_read && i_mul_read)
  ) else $error("cdb arbiter acknowledged alu and multiplier together");

  a_idle_after_reset: assert property (
    @(posedge clk_100mhz)
    sys_rst |=> !i_cdb_valid // bus quiet right after reset
  ) else $error("cdb valid high in the cycle after reset");

  a_valid_has_read: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst)
    i_cdb_valid |-> (i_alu_read != i_mul_read)
  ) else $error("cdb broadcast without exactly one unit acknowledged");

endmodule

bind cdb_arbiter ooo_core_props u_props (
  .clk_100mhz,
  .sys_rst,
  .i_alu_read(o_alu_read),
  .i_mul_read(o_mul_read),
  .i_cdb_valid(o_cdb_valid)
);

/* rtl/ooo_core.sv */
`timescale 1ns/10ps

module ooo_core
  import ooo_pkg::*;
(
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        i_inst_valid,
  input  logic [31:0] i_inst,
  output logic        o_inst_ready,
  output logic        o_commit_valid,
  output reg_addr_t   o_commit_rd,
  output data_t       o_commit_value
);
  logic        iq_head_valid, iq_pop;
  logic [31:0] iq_head_inst;
  logic        rob_full, rob_alloc, alu_issue, mul_issue;
  logic        alu_rs_free, mul_rs_free;
  reg_addr_t   rs1, rs2, rd;
  alu_func_t   alu_func, alu_rs_op;
  mul_func_t   mul_func, mul_rs_op;
  data_t       rf_val1, rf_val2, rob_val1, rob_val2, vi, vj;
  rob_ix_t     rf_tag1, rf_tag2, qi, qj, alloc_ix, commit_ix;
  logic        rf_tag1_valid, rf_tag2_valid, rob_done1, rob_done2, i_rdy, j_rdy;
  logic        cdb_valid;
  rob_ix_t     cdb_rob_ix;
  data_t       cdb_value;
  logic        alu_launch, alu_ready, alu_valid, alu_read;
  logic        mul_launch, mul_ready, mul_valid, mul_read;
  data_t       alu_a, alu_b, alu_result, mul_a, mul_b, mul_result;
  rob_ix_t     alu_rs_ix, alu_rob_ix, mul_rs_ix, mul_rob_ix;

  instruction_queue u_iq (
    .clk_100mhz, .sys_rst, .i_push(i_inst_valid), .i_inst, .i_pop(iq_pop),
    .o_ready(o_inst_ready), .o_head_valid(iq_head_valid), .o_head_inst(iq_head_inst)
  );

  dispatch u_dispatch (
    .i_head_valid(iq_head_valid), .i_head_inst(iq_head_inst), .i_rob_full(rob_full),
    .i_alu_rs_free(alu_rs_free), .i_mul_rs_free(mul_rs_free),
    .i_rf_val1(rf_val1), .i_rf_val2(rf_val2), .i_rf_tag1(rf_tag1), .i_rf_tag2(rf_tag2),
    .i_rf_tag1_valid(rf_tag1_valid), .i_rf_tag2_valid(rf_tag2_valid),
    .i_rob_val1(rob_val1), .i_rob_val2(rob_val2),
    .i_rob_done1(rob_done1), .i_rob_done2(rob_done2),
    .o_pop(iq_pop), .o_rob_alloc(rob_alloc), .o_alu_issue(alu_issue),
    .o_mul_issue(mul_issue), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd),
    .o_alu_func(alu_func), .o_mul_func(mul_func), .o_vi(vi), .o_vj(vj),
    .o_qi(qi), .o_qj(qj), .o_i_ready(i_rdy), .o_j_ready(j_rdy)
  );

  register_file u_rf (
    .clk_100mhz, .sys_rst, .i_rs1(rs1), .i_rs2(rs2),
    .i_issue(rob_alloc), .i_issue_rd(rd), .i_issue_ix(alloc_ix),
    .i_commit(o_commit_valid), .i_commit_rd(o_commit_rd), .i_commit_ix(commit_ix),
    .i_commit_value(o_commit_value), .o_val1(rf_val1), .o_val2(rf_val2),
    .o_tag1(rf_tag1), .o_tag2(rf_tag2),
    .o_tag1_valid(rf_tag1_valid), .o_tag2_valid(rf_tag2_valid)
  );

  reorder_buffer u_rob (
    .clk_100mhz, .sys_rst, .i_alloc(rob_alloc), .i_rd(rd),
    .i_cdb_valid(cdb_valid), .i_cdb_rob_ix(cdb_rob_ix), .i_cdb_value(cdb_value),
    .i_look_ix1(rf_tag1), .i_look_ix2(rf_tag2), .o_full(rob_full), .o_alloc_ix(alloc_ix),
    .o_look_val1(rob_val1), .o_look_val2(rob_val2),
    .o_look_done1(rob_done1), .o_look_done2(rob_done2),
    .o_commit_valid, .o_commit_rd, .o_commit_value, .o_commit_ix(commit_ix)
  );

  reservation_station #(.op_t(alu_func_t)) u_rs_alu (
    .clk_100mhz, .sys_rst, .i_issue(alu_issue), .i_op(alu_func), .i_vi(vi), .i_vj(vj),
    .i_qi(qi), .i_qj(qj), .i_i_ready(i_rdy), .i_j_ready(j_rdy), .i_rob_ix(alloc_ix),
    .i_cdb_valid(cdb_valid), .i_cdb_rob_ix(cdb_rob_ix), .i_cdb_value(cdb_value),
    .i_unit_ready(alu_ready), .o_free(alu_rs_free), .o_launch(alu_launch),
    .o_op(alu_rs_op), .o_a(alu_a), .o_b(alu_b), .o_rob_ix(alu_rs_ix)
  );

  reservation_station #(.op_t(mul_func_t)) u_rs_mul (
    .clk_100mhz, .sys_rst, .i_issue(mul_issue), .i_op(mul_func), .i_vi(vi), .i_vj(vj),
    .i_qi(qi), .i_qj(qj), .i_i_ready(i_rdy), .i_j_ready(j_rdy), .i_rob_ix(alloc_ix),
    .i_cdb_valid(cdb_valid), .i_cdb_rob_ix(cdb_rob_ix), .i_cdb_value(cdb_value),
    .i_unit_ready(mul_ready), .o_free(mul_rs_free), .o_launch(mul_launch),
    .o_op(mul_rs_op), .o_a(mul_a), .o_b(mul_b), .o_rob_ix(mul_rs_ix)
  );

  alu u_alu (
    .clk_100mhz, .sys_rst, .i_launch(alu_launch), .i_func(alu_rs_op),
    .i_a(alu_a), .i_b(alu_b), .i_rob_ix(alu_rs_ix), .i_read(alu_read),
    .o_ready(alu_ready), .o_valid(alu_valid), .o_result(alu_result), .o_rob_ix(alu_rob_ix)
  );

  multiplier u_mul (
    .clk_100mhz, .sys_rst, .i_launch(mul_launch), .i_func(mul_rs_op),
    .i_a(mul_a), .i_b(mul_b), .i_rob_ix(mul_rs_ix), .i_read(mul_read),
    .o_ready(mul_ready), .o_valid(mul_valid), .o_result(mul_result), .o_rob_ix(mul_rob_ix)
  );

  cdb_arbiter u_cdb (
    .clk_100mhz, .sys_rst,
    .i_alu_valid(alu_valid), .i_alu_result(alu_result), .i_alu_rob_ix(alu_rob_ix),
    .i_mul_valid(mul_valid), .i_mul_result(mul_result), .i_mul_rob_ix(mul_rob_ix),
    .o_alu_read(alu_read), .o_mul_read(mul_read), .o_cdb_valid(cdb_valid),
    .o_cdb_rob_ix(cdb_rob_ix), .o_cdb_value(cdb_value)
  );

endmodule

/* rtl/cdb_arbiter.sv */
`timescale 1ns/10ps

module cdb_arbiter
  import ooo_pkg::*;
(
  input  logic    clk_100mhz,
  input  logic    sys_rst,
  input  logic    i_alu_valid,
  input  data_t   i_alu_result,
  input  rob_ix_t i_alu_rob_ix,
  input  logic    i_mul_valid,
  input  data_t   i_mul_result,
  input  rob_ix_t i_mul_rob_ix,
  output logic    o_alu_read,
  output logic    o_mul_read,
  output logic    o_cdb_valid,
  output rob_ix_t o_cdb_rob_ix,
  output data_t   o_cdb_value
);
  logic alu_take, mul_take;

  // a unit being acked this cycle still shows valid, skip it
  assign alu_take = i_alu_valid && !o_alu_read;
  assign mul_take = i_mul_valid && !o_mul_read && !alu_take; // alu first

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_cdb_valid <= 1'b0;
      o_alu_read  <= 1'b0;
      o_mul_read  <= 1'b0;
    end else begin
      o_cdb_valid <= alu_take || mul_take;
      o_alu_read  <= alu_take;
      o_mul_read  <= mul_take;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    o_cdb_rob_ix <= alu_take ? i_alu_rob_ix : i_mul_rob_ix;
    o_cdb_value  <= alu_take ? i_alu_result : i_mul_result;
  end

endmodule

/* rtl/multiplier.sv */
`timescale 1ns/10ps

module multiplier
  import ooo_pkg::*;
(
  input  logic      clk_100mhz,
  input  logic      sys_rst,
  input  logic      i_launch,
  input  mul_func_t i_func,
  input  data_t     i_a, i_b,
  input  rob_ix_t   i_rob_ix,
  input  logic      i_read,
  output logic      o_ready,
  output logic      o_valid,
  output data_t     o_result,
  output rob_ix_t   o_rob_ix
);
  logic        busy;
  logic [$clog2(MUL_LATENCY+1)-1:0] cnt;
  mul_func_t   func_q;
  data_t       a_q, b_q;
  logic signed [63:0] prod_ss;
  logic [63:0] prod_uu;

  assign prod_ss = a_q * b_q;
  assign prod_uu = $unsigned(a_q) * $unsigned(b_q);
  assign o_ready = !busy && (!o_valid || i_read);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy    <= 1'b0;
      o_valid <= 1'b0;
    end else if (i_launch) begin
      busy    <= 1'b1;
      o_valid <= 1'b0;
    end else if (busy && cnt == 1) begin
      busy    <= 1'b0; // result lands MUL_LATENCY cycles after launch
      o_valid <= 1'b1;
    end else if (i_read) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_launch) begin
      cnt      <= $bits(cnt)'(MUL_LATENCY - 1);
      func_q   <= i_func;
      a_q      <= i_a;
      b_q      <= i_b;
      o_rob_ix <= i_rob_ix;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
    end
    if (busy && cnt == 1) begin
      case (func_q)
        MUL_HI_SS: o_result <= prod_ss[63:32];
        MUL_HI_UU: o_result <= prod_uu[63:32];
        default:   o_result <= prod_ss[31:0];
      endcase
    end
  end

endmodule

/* rtl/alu.sv */
`timescale 1ns/10ps

module alu
  import ooo_pkg::*;
(
  input  logic      clk_100mhz,
  input  logic      sys_rst,
  input  logic      i_launch,
  input  alu_func_t i_func,
  input  data_t     i_a, i_b,
  input  rob_ix_t   i_rob_ix,
  input  logic      i_read,
  output logic      o_ready,
  output logic      o_valid,
  output data_t     o_result,
  output rob_ix_t   o_rob_ix
);
  data_t res;

  always_comb begin
    case (i_func)
      ALU_ADD:  res = i_a + i_b;
      ALU_SUB:  res = i_a - i_b;
      ALU_SLL:  res = i_a << i_b[4:0];
      ALU_SLT:  res = data_t'(i_a < i_b);
      ALU_SLTU: res = data_t'($unsigned(i_a) < $unsigned(i_b));
      ALU_XOR:  res = i_a ^ i_b;
      ALU_SRL:  res = $unsigned(i_a) >> i_b[4:0];
      ALU_SRA:  res = i_a >>> i_b[4:0];
      ALU_OR:   res = i_a | i_b;
      ALU_AND:  res = i_a & i_b;
      default:  res = i_b; // pass_b
    endcase
  end

  assign o_ready = !o_valid || i_read; // free once cdb takes the result

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) o_valid <= 1'b0;
    else if (i_launch) o_valid <= 1'b1;
    else if (i_read) o_valid <= 1'b0;
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_launch) begin
      o_result <= res;
      o_rob_ix <= i_rob_ix;
    end
  end

endmodule

/* rtl/reservation_station.sv */
`timescale 1ns/10ps

module reservation_station
  import ooo_pkg::*;
#(
  parameter type op_t = alu_func_t
) (
  input  logic    clk_100mhz,
  input  logic    sys_rst,
  input  logic    i_issue,
  input  op_t     i_op,
  input  data_t   i_vi, i_vj,
  input  rob_ix_t i_qi, i_qj,
  input  logic    i_i_ready, i_j_ready,
  input  rob_ix_t i_rob_ix,
  input  logic    i_cdb_valid,
  input  rob_ix_t i_cdb_rob_ix,
  input  data_t   i_cdb_value,
  input  logic    i_unit_ready,
  output logic    o_free,
  output logic    o_launch,
  output op_t     o_op,
  output data_t   o_a, o_b,
  output rob_ix_t o_rob_ix
);
  logic    busy;
  logic    rdy_a, rdy_b;
  rob_ix_t qa, qb;
  rob_ix_t want_a, want_b;
  logic    have_a, have_b;
  logic    hit_a, hit_b;

  // tags looked for this cycle, fresh ones from dispatch on issue
  assign want_a = i_issue ? i_qi : qa;
  assign want_b = i_issue ? i_qj : qb;
  assign have_a = i_issue ? i_i_ready : rdy_a;
  assign have_b = i_issue ? i_j_ready : rdy_b;
  assign hit_a  = i_cdb_valid && !have_a && (i_cdb_rob_ix == want_a);
  assign hit_b  = i_cdb_valid && !have_b && (i_cdb_rob_ix == want_b);

  assign o_free   = !busy;
  assign o_launch = busy && rdy_a && rdy_b && i_unit_ready;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy  <= 1'b0;
      rdy_a <= 1'b0;
      rdy_b <= 1'b0;
    end else begin
      if (i_issue) busy <= 1'b1;
      else if (o_launch) busy <= 1'b0;
      rdy_a <= have_a || hit_a;
      rdy_b <= have_b || hit_b;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_issue) begin
      o_op     <= i_op;
      o_rob_ix <= i_rob_ix;
      qa       <= i_qi;
      qb       <= i_qj;
    end
    if (hit_a) o_a <= i_cdb_value; // wake-up from cdb
    else if (i_issue) o_a <= i_vi;
    if (hit_b) o_b <= i_cdb_value;
    else if (i_issue) o_b <= i_vj;
  end

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer
  import ooo_pkg::*;
(
  input  logic      clk_100mhz,
  input  logic      sys_rst,
  input  logic      i_alloc,
  input  reg_addr_t i_rd,
  input  logic      i_cdb_valid,
  input  rob_ix_t   i_cdb_rob_ix,
  input  data_t     i_cdb_value,
  input  rob_ix_t   i_look_ix1, i_look_ix2,
  output logic      o_full,
  output rob_ix_t   o_alloc_ix,
  output data_t     o_look_val1, o_look_val2,
  output logic      o_look_done1, o_look_done2,
  output logic      o_commit_valid,
  output reg_addr_t o_commit_rd,
  output data_t     o_commit_value,
  output rob_ix_t   o_commit_ix
);
  logic      busy  [ROB_DEPTH];
  logic      done  [ROB_DEPTH];
  reg_addr_t rd    [ROB_DEPTH];
  data_t     value [ROB_DEPTH];
  rob_ix_t   head, tail;
  logic [$clog2(ROB_DEPTH+1)-1:0] count;

  assign o_full         = (count == ROB_DEPTH);
  assign o_alloc_ix     = tail;
  assign o_look_val1    = value[i_look_ix1];
  assign o_look_val2    = value[i_look_ix2];
  assign o_look_done1   = done[i_look_ix1];
  assign o_look_done2   = done[i_look_ix2];
  assign o_commit_valid = busy[head] && done[head]; // in order, one per cycle
  assign o_commit_rd    = rd[head];
  assign o_commit_value = value[head];
  assign o_commit_ix    = head;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int e = 0; e < ROB_DEPTH; e++) begin
        busy[e] <= 1'b0;
        done[e] <= 1'b0;
      end
    end else begin
      if (i_cdb_valid) done[i_cdb_rob_ix] <= 1'b1;
      if (o_commit_valid) begin
        busy[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      if (i_alloc && !o_full) begin
        busy[tail] <= 1'b1;
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
      count <= count + (i_alloc && !o_full) - o_commit_valid;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc && !o_full) rd[tail] <= i_rd;
    if (i_cdb_valid) value[i_cdb_rob_ix] <= i_cdb_value;
  end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/10ps

module register_file
  import ooo_pkg::*;
(
  input  logic      clk_100mhz,
  input  logic      sys_rst,
  input  reg_addr_t i_rs1, i_rs2,
  input  logic      i_issue,
  input  reg_addr_t i_issue_rd,
  input  rob_ix_t   i_issue_ix,
  input  logic      i_commit,
  input  reg_addr_t i_commit_rd,
  input  rob_ix_t   i_commit_ix,
  input  data_t     i_commit_value,
  output data_t     o_val1, o_val2,
  output rob_ix_t   o_tag1, o_tag2,
  output logic      o_tag1_valid, o_tag2_valid
);
  data_t   regs  [32];
  rob_ix_t tag   [32];
  logic    tag_v [32];

  assign o_val1       = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_val2       = (i_rs2 == '0) ? '0 : regs[i_rs2];
  assign o_tag1       = tag[i_rs1];
  assign o_tag2       = tag[i_rs2];
  assign o_tag1_valid = tag_v[i_rs1];
  assign o_tag2_valid = tag_v[i_rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int r = 0; r < 32; r++) begin
        regs[r]  <= '0; // architectural state starts at zero
        tag_v[r] <= 1'b0;
      end
    end else begin
      if (i_commit && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        if (tag[i_commit_rd] == i_commit_ix) tag_v[i_commit_rd] <= 1'b0; // still latest writer
      end
      if (i_issue && i_issue_rd != '0) tag_v[i_issue_rd] <= 1'b1; // new tag wins
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_issue && i_issue_rd != '0) tag[i_issue_rd] <= i_issue_ix;
  end

endmodule

/* rtl/dispatch.sv */
`timescale 1ns/10ps

module dispatch
  import ooo_pkg::*;
(
  input  logic        i_head_valid,
  input  logic [31:0] i_head_inst,
  input  logic        i_rob_full,
  input  logic        i_alu_rs_free,
  input  logic        i_mul_rs_free,
  input  data_t       i_rf_val1, i_rf_val2,
  input  rob_ix_t     i_rf_tag1, i_rf_tag2,
  input  logic        i_rf_tag1_valid, i_rf_tag2_valid,
  input  data_t       i_rob_val1, i_rob_val2,
  input  logic        i_rob_done1, i_rob_done2,
  output logic        o_pop,
  output logic        o_rob_alloc,
  output logic        o_alu_issue,
  output logic        o_mul_issue,
  output reg_addr_t   o_rs1, o_rs2, o_rd,
  output alu_func_t   o_alu_func,
  output mul_func_t   o_mul_func,
  output data_t       o_vi, o_vj,
  output rob_ix_t     o_qi, o_qj,
  output logic        o_i_ready, o_j_ready
);
  itype_t     itype;
  data_t      imm;
  logic [6:0] opcode, funct7;
  logic [2:0] funct3;
  logic       is_alu;

  function automatic alu_func_t alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = i_head_inst[6:0];
  assign funct3 = i_head_inst[14:12];
  assign funct7 = i_head_inst[31:25];
  assign o_rd   = i_head_inst[11:7];
  assign o_rs1  = i_head_inst[19:15];
  assign o_rs2  = i_head_inst[24:20];
  assign o_qi   = i_rf_tag1;
  assign o_qj   = i_rf_tag2;

  always_comb begin
    itype      = IT_NOP;
    o_alu_func = ALU_ADD;
    o_mul_func = MUL_LO;
    imm        = data_t'({{20{i_head_inst[31]}}, i_head_inst[31:20]}); // i-type immediate
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000001) begin
          itype = IT_MUL;
          case (funct3)
            3'b000:  o_mul_func = MUL_LO;
            3'b001:  o_mul_func = MUL_HI_SS;
            3'b011:  o_mul_func = MUL_HI_UU;
            default: itype = IT_NOP; // mulhsu and divides
          endcase
        end else if (funct7 == 7'b0000000 ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          itype      = IT_OP;
          o_alu_func = alu_decode(funct3, funct7[5]);
        end
      end
      OPC_OPIMM: begin
        itype      = IT_OPIMM;
        o_alu_func = alu_decode(funct3, funct3 == 3'b101 && funct7[5]); // addi is never sub
        if (funct3 == 3'b001 && funct7 != 7'b0000000) itype = IT_NOP;
        if (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0000000) itype = IT_NOP;
      end
      OPC_LUI: begin
        itype      = IT_LUI;
        o_alu_func = ALU_PASS_B;
        imm        = data_t'({i_head_inst[31:12], 12'b0});
      end
      default: itype = IT_NOP;
    endcase
  end

  // operand source: register file, finished rob entry, or wait on tag
  always_comb begin
    o_vi      = (i_rf_tag1_valid && i_rob_done1) ? i_rob_val1 : i_rf_val1;
    o_i_ready = !i_rf_tag1_valid || i_rob_done1 || itype == IT_LUI; // lui ignores rs1
    o_vj      = (i_rf_tag2_valid && i_rob_done2) ? i_rob_val2 : i_rf_val2;
    o_j_ready = !i_rf_tag2_valid || i_rob_done2;
    if (itype == IT_OPIMM || itype == IT_LUI) begin
      o_vj      = imm;
      o_j_ready = 1'b1;
    end
  end

  assign is_alu      = (itype == IT_OP) || (itype == IT_OPIMM) || (itype == IT_LUI);
  assign o_alu_issue = i_head_valid && is_alu && !i_rob_full && i_alu_rs_free;
  assign o_mul_issue = i_head_valid && itype == IT_MUL && !i_rob_full && i_mul_rs_free;
  assign o_rob_alloc = o_alu_issue || o_mul_issue;
  assign o_pop       = o_rob_alloc || (i_head_valid && itype == IT_NOP);

endmodule

/* rtl/instruction_queue.sv */
`timescale 1ns/10ps

module instruction_queue
  import ooo_pkg::*;
(
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        i_push,
  input  logic [31:0] i_inst,
  input  logic        i_pop,
  output logic        o_ready,
  output logic        o_head_valid,
  output logic [31:0] o_head_inst
);
  logic [31:0] mem [IQ_DEPTH];
  logic [$clog2(IQ_DEPTH)-1:0] wr_ptr, rd_ptr;
  logic [$clog2(IQ_DEPTH+1)-1:0] count;
  logic push_ok, pop_ok;

  assign o_ready      = (count != IQ_DEPTH);
  assign o_head_valid = (count != 0);
  assign o_head_inst  = mem[rd_ptr];
  assign push_ok      = i_push && o_ready; // word offered while full is dropped
  assign pop_ok       = i_pop && o_head_valid;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
      count <= count + push_ok - pop_ok;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (push_ok) mem[wr_ptr] <= i_inst;
  end

endmodule

/* rtl/ooo_pkg.sv */
package ooo_pkg;

  localparam int XLEN        = 32;
  localparam int ROB_DEPTH   = 8;
  localparam int IQ_DEPTH    = 4;
  localparam int MUL_LATENCY = 3; // launch to result valid

  typedef logic signed [XLEN-1:0]       data_t;
  typedef logic [4:0]                   reg_addr_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_ix_t;

  typedef enum logic [2:0] {
    IT_OP,
    IT_OPIMM,
    IT_LUI,
    IT_MUL,
    IT_NOP // anything not supported, dropped at dispatch
  } itype_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B // lui
  } alu_func_t;

  typedef enum logic [1:0] {
    MUL_LO,
    MUL_HI_SS,
    MUL_HI_UU
  } mul_func_t;

  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;

endpackage
